//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_dual_issue
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+logic
+incdir+test
logic/dual_issue_pkg.sv
logic/credit_fifo.sv
logic/pair_decode.sv
logic/issue_split.sv
logic/exec_commit.sv
logic/dual_issue_top.sv
test/tb_dual_issue.sv

//--- logic/credit_fifo.sv
`timescale 1ns/10ps
`include "dual_issue_params.svh"

module credit_fifo #(
    parameter int DEPTH = `DI_CREDITS,
    parameter int WIDTH = `DI_XLEN
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                wr_valid,
    input  logic [`DI_XLEN-1:0] wr_pc,
    input  logic [WIDTH-1:0]    wr_data0,
    input  logic [WIDTH-1:0]    wr_data1,
    output logic                head_valid,
    output logic [`DI_XLEN-1:0] head_pc,
    output logic [WIDTH-1:0]    head_data0,
    output logic [WIDTH-1:0]    head_data1,
    input  logic                pop,
    output logic                credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`DI_XLEN-1:0] pc_mem [DEPTH];
    logic [WIDTH-1:0]    d0_mem [DEPTH];
    logic [WIDTH-1:0]    d1_mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         count;
    logic                do_pop;

    // wrap for any depth, not only powers of two
    function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_pc    = pc_mem[rd_ptr];
    assign head_data0 = d0_mem[rd_ptr];
    assign head_data1 = d1_mem[rd_ptr];
    assign do_pop     = pop && head_valid;
    // one credit back per freed entry
    assign credit     = do_pop;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid)
                wr_ptr <= bump(wr_ptr);
            if (do_pop)
                rd_ptr <= bump(rd_ptr);
            count <= count + (AW+1)'(wr_valid) - (AW+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            pc_mem[wr_ptr] <= wr_pc;
            d0_mem[wr_ptr] <= wr_data0;
            d1_mem[wr_ptr] <= wr_data1;
        end
    end

    // senders must stay within their credits
    assert property (@(posedge clk) disable iff (!rstn)
        wr_valid |-> (count < (AW+1)'(DEPTH)) || pop);
    assert property (@(posedge clk) disable iff (!rstn)
        pop |-> head_valid);

endmodule

//--- logic/dual_issue_params.svh
`ifndef DUAL_ISSUE_PARAMS_SVH
`define DUAL_ISSUE_PARAMS_SVH

// data path and register file
`define DI_XLEN 32
`define DI_NREG 32
`define DI_RW 5

// buffer depth, also the starting credit count of each sender
`define DI_CREDITS 2

// all-zero word, decodes as a nop
`define DI_INST_NOP 32'h0000_0000

// raw instruction fields
`define DI_F_OP 31:26
`define DI_F_RD 25:21
`define DI_F_RJ 20:16
`define DI_F_RK 15:11
`define DI_F_IMM 15:0

// decoded slot word held in dec_buf: op, rd, rj, rk, imm
`define DI_DEC_W 53

`endif

//--- logic/dual_issue_pkg.sv
package dual_issue_pkg;

    // decoded opcodes, raw values 8 and up fold into op_nop
    typedef enum logic [5:0] {
        op_nop  = 6'd0,
        op_add  = 6'd1,
        op_sub  = 6'd2,
        op_and  = 6'd3,
        op_or   = 6'd4,
        op_xor  = 6'd5,
        op_addi = 6'd6,
        op_priv = 6'd7
    } opcode_e;

    // issue state, also carried to commit
    typedef enum logic [1:0] {
        mode_pair   = 2'd0,
        mode_first  = 2'd1,
        mode_second = 2'd2
    } issue_mode_e;

endpackage

//--- logic/dual_issue_top.sv
`timescale 1ns/10ps
`include "dual_issue_params.svh"

module dual_issue_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         pair_valid,
    input  logic [`DI_XLEN-1:0]          pair_pc,
    input  logic [31:0]                  pair_inst0,
    input  logic [31:0]                  pair_inst1,
    output logic                         pair_credit,
    output logic                         commit_valid0,
    output logic                         commit_valid1,
    output dual_issue_pkg::issue_mode_e  commit_mode,
    output logic [`DI_XLEN-1:0]          commit_pc0,
    output logic [`DI_XLEN-1:0]          commit_pc1,
    output logic [`DI_RW-1:0]            commit_rd0,
    output logic [`DI_RW-1:0]            commit_rd1,
    output logic [`DI_XLEN-1:0]          commit_value0,
    output logic [`DI_XLEN-1:0]          commit_value1
);

    // raw pair buffer to decode
    logic                in_valid;
    logic [`DI_XLEN-1:0] in_pc;
    logic [31:0]         in_inst0;
    logic [31:0]         in_inst1;
    logic                in_pop;

    // decode to dec_buf
    logic                    dec_valid;
    logic                    dec_credit;
    logic [`DI_XLEN-1:0]     dec_pc;
    dual_issue_pkg::opcode_e dec_op0;
    dual_issue_pkg::opcode_e dec_op1;
    logic [`DI_RW-1:0]       dec_rd0;
    logic [`DI_RW-1:0]       dec_rj0;
    logic [`DI_RW-1:0]       dec_rk0;
    logic [`DI_RW-1:0]       dec_rd1;
    logic [`DI_RW-1:0]       dec_rj1;
    logic [`DI_RW-1:0]       dec_rk1;
    logic [`DI_XLEN-1:0]     dec_imm0;
    logic [`DI_XLEN-1:0]     dec_imm1;

    // dec_buf head, packed as {op[52:47], rd[46:42], rj[41:37], rk[36:32], imm[31:0]}
    logic                 dh_valid;
    logic [`DI_XLEN-1:0]  dh_pc;
    logic [`DI_DEC_W-1:0] dh_word0;
    logic [`DI_DEC_W-1:0] dh_word1;
    logic                 dh_pop;

    // issue to execute
    logic                        issue_valid;
    dual_issue_pkg::issue_mode_e issue_mode;
    logic [`DI_XLEN-1:0]         issue_pc0;
    logic [`DI_XLEN-1:0]         issue_pc1;
    dual_issue_pkg::opcode_e     issue_op0;
    dual_issue_pkg::opcode_e     issue_op1;
    logic [`DI_RW-1:0]           issue_rd0;
    logic [`DI_RW-1:0]           issue_rj0;
    logic [`DI_RW-1:0]           issue_rk0;
    logic [`DI_RW-1:0]           issue_rd1;
    logic [`DI_RW-1:0]           issue_rj1;
    logic [`DI_RW-1:0]           issue_rk1;
    logic [`DI_XLEN-1:0]         issue_imm0;
    logic [`DI_XLEN-1:0]         issue_imm1;

    credit_fifo #(.DEPTH(`DI_CREDITS), .WIDTH(32)) in_buf (
        .clk(clk), .rstn(rstn),
        .wr_valid(pair_valid), .wr_pc(pair_pc),
        .wr_data0(pair_inst0), .wr_data1(pair_inst1),
        .head_valid(in_valid), .head_pc(in_pc),
        .head_data0(in_inst0), .head_data1(in_inst1),
        .pop(in_pop), .credit(pair_credit)
    );

    pair_decode u_decode (
        .clk(clk), .rstn(rstn),
        .head_valid(in_valid), .head_pc(in_pc),
        .head_inst0(in_inst0), .head_inst1(in_inst1),
        .pop(in_pop), .dec_credit(dec_credit),
        .dec_valid(dec_valid), .dec_pc(dec_pc),
        .op0(dec_op0), .op1(dec_op1),
        .rd0(dec_rd0), .rj0(dec_rj0), .rk0(dec_rk0),
        .rd1(dec_rd1), .rj1(dec_rj1), .rk1(dec_rk1),
        .imm0(dec_imm0), .imm1(dec_imm1)
    );

    credit_fifo #(.DEPTH(`DI_CREDITS), .WIDTH(`DI_DEC_W)) dec_buf (
        .clk(clk), .rstn(rstn),
        .wr_valid(dec_valid), .wr_pc(dec_pc),
        .wr_data0({dec_op0, dec_rd0, dec_rj0, dec_rk0, dec_imm0}),
        .wr_data1({dec_op1, dec_rd1, dec_rj1, dec_rk1, dec_imm1}),
        .head_valid(dh_valid), .head_pc(dh_pc),
        .head_data0(dh_word0), .head_data1(dh_word1),
        .pop(dh_pop), .credit(dec_credit)
    );

    issue_split u_issue (
        .clk(clk), .rstn(rstn),
        .head_valid(dh_valid), .head_pc(dh_pc),
        .head_op0(dual_issue_pkg::opcode_e'(dh_word0[52:47])),
        .head_op1(dual_issue_pkg::opcode_e'(dh_word1[52:47])),
        .head_rd0(dh_word0[46:42]), .head_rj0(dh_word0[41:37]), .head_rk0(dh_word0[36:32]),
        .head_rd1(dh_word1[46:42]), .head_rj1(dh_word1[41:37]), .head_rk1(dh_word1[36:32]),
        .head_imm0(dh_word0[31:0]), .head_imm1(dh_word1[31:0]),
        .pop(dh_pop), .issue_valid(issue_valid), .issue_mode(issue_mode),
        .issue_pc0(issue_pc0), .issue_pc1(issue_pc1),
        .issue_op0(issue_op0), .issue_op1(issue_op1),
        .issue_rd0(issue_rd0), .issue_rj0(issue_rj0), .issue_rk0(issue_rk0),
        .issue_rd1(issue_rd1), .issue_rj1(issue_rj1), .issue_rk1(issue_rk1),
        .issue_imm0(issue_imm0), .issue_imm1(issue_imm1)
    );

    exec_commit u_exec (
        .clk(clk), .rstn(rstn),
        .issue_valid(issue_valid), .issue_mode(issue_mode),
        .issue_pc0(issue_pc0), .issue_pc1(issue_pc1),
        .issue_op0(issue_op0), .issue_op1(issue_op1),
        .issue_rd0(issue_rd0), .issue_rj0(issue_rj0), .issue_rk0(issue_rk0),
        .issue_rd1(issue_rd1), .issue_rj1(issue_rj1), .issue_rk1(issue_rk1),
        .issue_imm0(issue_imm0), .issue_imm1(issue_imm1),
        .commit_valid0(commit_valid0), .commit_valid1(commit_valid1),
        .commit_mode(commit_mode),
        .commit_pc0(commit_pc0), .commit_pc1(commit_pc1),
        .commit_rd0(commit_rd0), .commit_rd1(commit_rd1),
        .commit_value0(commit_value0), .commit_value1(commit_value1)
    );

endmodule

//--- logic/exec_commit.sv
`timescale 1ns/10ps
`include "dual_issue_params.svh"

module exec_commit (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         issue_valid,
    input  dual_issue_pkg::issue_mode_e  issue_mode,
    input  logic [`DI_XLEN-1:0]          issue_pc0,
    input  logic [`DI_XLEN-1:0]          issue_pc1,
    input  dual_issue_pkg::opcode_e      issue_op0,
    input  dual_issue_pkg::opcode_e      issue_op1,
    input  logic [`DI_RW-1:0]            issue_rd0,
    input  logic [`DI_RW-1:0]            issue_rj0,
    input  logic [`DI_RW-1:0]            issue_rk0,
    input  logic [`DI_RW-1:0]            issue_rd1,
    input  logic [`DI_RW-1:0]            issue_rj1,
    input  logic [`DI_RW-1:0]            issue_rk1,
    input  logic [`DI_XLEN-1:0]          issue_imm0,
    input  logic [`DI_XLEN-1:0]          issue_imm1,
    output logic                         commit_valid0,
    output logic                         commit_valid1,
    output dual_issue_pkg::issue_mode_e  commit_mode,
    output logic [`DI_XLEN-1:0]          commit_pc0,
    output logic [`DI_XLEN-1:0]          commit_pc1,
    output logic [`DI_RW-1:0]            commit_rd0,
    output logic [`DI_RW-1:0]            commit_rd1,
    output logic [`DI_XLEN-1:0]          commit_value0,
    output logic [`DI_XLEN-1:0]          commit_value1
);

    logic [`DI_XLEN-1:0] rf [`DI_NREG];
    logic [`DI_XLEN-1:0] src_j0;
    logic [`DI_XLEN-1:0] src_k0;
    logic [`DI_XLEN-1:0] src_j1;
    logic [`DI_XLEN-1:0] src_k1;
    logic [`DI_XLEN-1:0] res0;
    logic [`DI_XLEN-1:0] res1;
    logic                we0;
    logic                we1;

    function automatic logic [`DI_XLEN-1:0] alu(input dual_issue_pkg::opcode_e op,
                                                 input logic [`DI_XLEN-1:0] a,
                                                 input logic [`DI_XLEN-1:0] b,
                                                 input logic [`DI_XLEN-1:0] imm);
        case (op)
            dual_issue_pkg::op_add:  return a + b;
            dual_issue_pkg::op_sub:  return a - b;
            dual_issue_pkg::op_and:  return a & b;
            dual_issue_pkg::op_or:   return a | b;
            dual_issue_pkg::op_xor:  return a ^ b;
            dual_issue_pkg::op_addi: return a + imm;
            // privileged op just moves rj
            dual_issue_pkg::op_priv: return a;
            default:                 return '0;
        endcase
    endfunction

    // r0 reads as zero
    assign src_j0 = (issue_rj0 == '0) ? '0 : rf[issue_rj0];
    assign src_k0 = (issue_rk0 == '0) ? '0 : rf[issue_rk0];
    assign src_j1 = (issue_rj1 == '0) ? '0 : rf[issue_rj1];
    assign src_k1 = (issue_rk1 == '0) ? '0 : rf[issue_rk1];

    assign res0 = alu(issue_op0, src_j0, src_k0, issue_imm0);
    assign res1 = alu(issue_op1, src_j1, src_k1, issue_imm1);
    assign we0  = issue_valid && (issue_op0 != dual_issue_pkg::op_nop);
    assign we1  = issue_valid && (issue_op1 != dual_issue_pkg::op_nop);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            commit_valid0 <= 1'b0;
            commit_valid1 <= 1'b0;
        end else begin
            commit_valid0 <= we0;
            commit_valid1 <= we1;
        end
    end

    always_ff @(posedge clk) begin
        // slot 1 written last so it wins on a shared rd
        if (we0 && issue_rd0 != '0)
            rf[issue_rd0] <= res0;
        if (we1 && issue_rd1 != '0)
            rf[issue_rd1] <= res1;
        commit_mode   <= issue_mode;
        commit_pc0    <= issue_pc0;
        commit_pc1    <= issue_pc1;
        commit_rd0    <= issue_rd0;
        commit_rd1    <= issue_rd1;
        commit_value0 <= res0;
        commit_value1 <= res1;
    end

endmodule

//--- logic/issue_split.sv
`timescale 1ns/10ps
`include "dual_issue_params.svh"

module issue_split (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         head_valid,
    input  logic [`DI_XLEN-1:0]          head_pc,
    input  dual_issue_pkg::opcode_e      head_op0,
    input  dual_issue_pkg::opcode_e      head_op1,
    input  logic [`DI_RW-1:0]            head_rd0,
    input  logic [`DI_RW-1:0]            head_rj0,
    input  logic [`DI_RW-1:0]            head_rk0,
    input  logic [`DI_RW-1:0]            head_rd1,
    input  logic [`DI_RW-1:0]            head_rj1,
    input  logic [`DI_RW-1:0]            head_rk1,
    input  logic [`DI_XLEN-1:0]          head_imm0,
    input  logic [`DI_XLEN-1:0]          head_imm1,
    output logic                         pop,
    output logic                         issue_valid,
    output dual_issue_pkg::issue_mode_e  issue_mode,
    output logic [`DI_XLEN-1:0]          issue_pc0,
    output logic [`DI_XLEN-1:0]          issue_pc1,
    output dual_issue_pkg::opcode_e      issue_op0,
    output dual_issue_pkg::opcode_e      issue_op1,
    output logic [`DI_RW-1:0]            issue_rd0,
    output logic [`DI_RW-1:0]            issue_rj0,
    output logic [`DI_RW-1:0]            issue_rk0,
    output logic [`DI_RW-1:0]            issue_rd1,
    output logic [`DI_RW-1:0]            issue_rj1,
    output logic [`DI_RW-1:0]            issue_rk1,
    output logic [`DI_XLEN-1:0]          issue_imm0,
    output logic [`DI_XLEN-1:0]          issue_imm1
);

    localparam logic [31:0] NOP_WORD = `DI_INST_NOP;

    dual_issue_pkg::issue_mode_e state;
    logic                        dual_ok;

    function automatic logic is_alu(input dual_issue_pkg::opcode_e op);
        return (op >= dual_issue_pkg::op_add) && (op <= dual_issue_pkg::op_addi);
    endfunction

    // independent alu pair, no raw hazard from slot 0 into slot 1
    assign dual_ok = is_alu(head_op0) && is_alu(head_op1)
                  && (head_op1 != dual_issue_pkg::op_nop)
                  && ((head_rd0 == '0)
                      || ((head_rd0 != head_rj1) && (head_rd0 != head_rk1)));

    assign issue_valid = head_valid;
    assign issue_mode  = (state == dual_issue_pkg::mode_second) ? dual_issue_pkg::mode_second :
                         dual_ok ? dual_issue_pkg::mode_pair : dual_issue_pkg::mode_first;
    // head leaves dec_buf once the whole pair is out
    assign pop         = head_valid && (issue_mode != dual_issue_pkg::mode_first);
    assign issue_pc1   = issue_pc0 + `DI_XLEN'd4;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= dual_issue_pkg::mode_pair;
        end else if (head_valid) begin
            if (state == dual_issue_pkg::mode_second)
                state <= dual_issue_pkg::mode_pair;
            else if (!dual_ok)
                state <= dual_issue_pkg::mode_second;
        end
    end

    always_comb begin
        issue_pc0  = head_pc;
        issue_op0  = head_op0;
        issue_rd0  = head_rd0;
        issue_rj0  = head_rj0;
        issue_rk0  = head_rk0;
        issue_imm0 = head_imm0;
        issue_op1  = head_op1;
        issue_rd1  = head_rd1;
        issue_rj1  = head_rj1;
        issue_rk1  = head_rk1;
        issue_imm1 = head_imm1;
        // second half of a split pair moves into slot 0
        if (state == dual_issue_pkg::mode_second) begin
            issue_pc0  = head_pc + `DI_XLEN'd4;
            issue_op0  = head_op1;
            issue_rd0  = head_rd1;
            issue_rj0  = head_rj1;
            issue_rk0  = head_rk1;
            issue_imm0 = head_imm1;
        end
        if (issue_mode != dual_issue_pkg::mode_pair) begin
            issue_op1  = dual_issue_pkg::opcode_e'(NOP_WORD[`DI_F_OP]);
            issue_rd1  = NOP_WORD[`DI_F_RD];
            issue_rj1  = NOP_WORD[`DI_F_RJ];
            issue_rk1  = NOP_WORD[`DI_F_RK];
            issue_imm1 = {{(`DI_XLEN-16){NOP_WORD[15]}}, NOP_WORD[`DI_F_IMM]};
        end
    end

    // a split pair keeps its head in dec_buf until the second half issues
    assert property (@(posedge clk) disable iff (!rstn)
        (issue_valid && issue_mode == dual_issue_pkg::mode_first)
        |-> !pop ##1 (head_valid && $stable(head_pc) && $stable(head_rd1)));

endmodule

//--- logic/pair_decode.sv
`timescale 1ns/10ps
`include "dual_issue_params.svh"

module pair_decode (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     head_valid,
    input  logic [`DI_XLEN-1:0]      head_pc,
    input  logic [31:0]              head_inst0,
    input  logic [31:0]              head_inst1,
    output logic                     pop,
    input  logic                     dec_credit,
    output logic                     dec_valid,
    output logic [`DI_XLEN-1:0]      dec_pc,
    output dual_issue_pkg::opcode_e  op0,
    output dual_issue_pkg::opcode_e  op1,
    output logic [`DI_RW-1:0]        rd0,
    output logic [`DI_RW-1:0]        rj0,
    output logic [`DI_RW-1:0]        rk0,
    output logic [`DI_RW-1:0]        rd1,
    output logic [`DI_RW-1:0]        rj1,
    output logic [`DI_RW-1:0]        rk1,
    output logic [`DI_XLEN-1:0]      imm0,
    output logic [`DI_XLEN-1:0]      imm1
);

    localparam int CW = $clog2(`DI_CREDITS + 1);

    logic [CW-1:0] credit_cnt;

    function automatic dual_issue_pkg::opcode_e map_op(input logic [5:0] raw);
        if (raw <= 6'd7)
            return dual_issue_pkg::opcode_e'(raw);
        return dual_issue_pkg::op_nop;
    endfunction

    function automatic logic [`DI_XLEN-1:0] sext(input logic [15:0] imm);
        return {{(`DI_XLEN-16){imm[15]}}, imm};
    endfunction

    // pop only with room reserved in dec_buf
    assign pop = head_valid && (credit_cnt != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_cnt <= CW'(`DI_CREDITS);
            dec_valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CW'(pop) + CW'(dec_credit);
            dec_valid  <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_pc <= head_pc;
            op0    <= map_op(head_inst0[`DI_F_OP]);
            rd0    <= head_inst0[`DI_F_RD];
            rj0    <= head_inst0[`DI_F_RJ];
            rk0    <= head_inst0[`DI_F_RK];
            imm0   <= sext(head_inst0[`DI_F_IMM]);
            op1    <= map_op(head_inst1[`DI_F_OP]);
            rd1    <= head_inst1[`DI_F_RD];
            rj1    <= head_inst1[`DI_F_RJ];
            rk1    <= head_inst1[`DI_F_RK];
            imm1   <= sext(head_inst1[`DI_F_IMM]);
        end
    end

    // dec_buf never hands back more than was spent
    assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= CW'(`DI_CREDITS));

endmodule

//--- test/dual_issue_model.svh
`ifndef DUAL_ISSUE_MODEL_SVH
`define DUAL_ISSUE_MODEL_SVH

`include "dual_issue_params.svh"

// architectural registers and the commits the DUT still owes, in program order
logic [`DI_XLEN-1:0]         model_rf [`DI_NREG];
logic [`DI_XLEN-1:0]         exp_pc [$];
logic [`DI_RW-1:0]           exp_rd [$];
logic [`DI_XLEN-1:0]         exp_val [$];
dual_issue_pkg::issue_mode_e exp_mode [$];

function automatic dual_issue_pkg::opcode_e model_op(input logic [31:0] inst);
    // undefined opcodes behave as nop
    if (inst[`DI_F_OP] > 6'd7)
        return dual_issue_pkg::op_nop;
    return dual_issue_pkg::opcode_e'(inst[`DI_F_OP]);
endfunction

function automatic logic model_is_alu(input dual_issue_pkg::opcode_e op);
    return (op >= dual_issue_pkg::op_add) && (op <= dual_issue_pkg::op_addi);
endfunction

task automatic model_exec(input logic [`DI_XLEN-1:0] pc, input logic [31:0] inst,
                          input dual_issue_pkg::issue_mode_e mode);
    dual_issue_pkg::opcode_e op;
    logic [`DI_XLEN-1:0]     a;
    logic [`DI_XLEN-1:0]     b;
    logic [`DI_XLEN-1:0]     imm;
    logic [`DI_XLEN-1:0]     res;
    op  = model_op(inst);
    a   = model_rf[inst[`DI_F_RJ]];
    b   = model_rf[inst[`DI_F_RK]];
    imm = {{(`DI_XLEN-16){inst[15]}}, inst[15:0]};
    case (op)
        dual_issue_pkg::op_add:  res = a + b;
        dual_issue_pkg::op_sub:  res = a - b;
        dual_issue_pkg::op_and:  res = a & b;
        dual_issue_pkg::op_or:   res = a | b;
        dual_issue_pkg::op_xor:  res = a ^ b;
        dual_issue_pkg::op_addi: res = a + imm;
        // privileged op copies rj
        default:                 res = a;
    endcase
    if (op != dual_issue_pkg::op_nop) begin
        exp_pc.push_back(pc);
        exp_rd.push_back(inst[`DI_F_RD]);
        exp_val.push_back(res);
        exp_mode.push_back(mode);
        // r0 stays zero
        if (inst[`DI_F_RD] != '0)
            model_rf[inst[`DI_F_RD]] = res;
    end
endtask

task automatic model_pair(input logic [`DI_XLEN-1:0] pc, input logic [31:0] inst0,
                          input logic [31:0] inst1);
    dual_issue_pkg::opcode_e op0;
    dual_issue_pkg::opcode_e op1;
    logic                    dual;
    op0  = model_op(inst0);
    op1  = model_op(inst1);
    // two alu ops, and slot 1 must not read what slot 0 writes
    dual = model_is_alu(op0) && model_is_alu(op1)
        && ((inst0[`DI_F_RD] == '0)
            || ((inst0[`DI_F_RD] != inst1[`DI_F_RJ]) && (inst0[`DI_F_RD] != inst1[`DI_F_RK])));
    // in program order either way, a dual pair has no hazard to break it
    model_exec(pc, inst0, dual ? dual_issue_pkg::mode_pair : dual_issue_pkg::mode_first);
    model_exec(pc + `DI_XLEN'd4, inst1,
               dual ? dual_issue_pkg::mode_pair : dual_issue_pkg::mode_second);
endtask

`endif

//--- test/tb_dual_issue.sv
`timescale 1ns/10ps
`include "dual_issue_params.svh"

module tb_dual_issue;

    localparam int N_RANDOM   = 300;
    localparam int N_DIRECTED = 40;
    // 8 cycles of 8 ns per pair at worst, plus slack for resets and drains
    localparam int WATCH_NS   = (N_RANDOM + N_DIRECTED) * 8 * 8 + 2000;

    localparam logic [5:0] OP_ADD  = 6'(dual_issue_pkg::op_add);
    localparam logic [5:0] OP_SUB  = 6'(dual_issue_pkg::op_sub);
    localparam logic [5:0] OP_AND  = 6'(dual_issue_pkg::op_and);
    localparam logic [5:0] OP_OR   = 6'(dual_issue_pkg::op_or);
    localparam logic [5:0] OP_XOR  = 6'(dual_issue_pkg::op_xor);
    localparam logic [5:0] OP_PRIV = 6'(dual_issue_pkg::op_priv);
    localparam logic [5:0] OP_BAD  = 6'h2a;

    logic                        clk;
    logic                        rstn;
    logic                        pair_valid;
    logic [`DI_XLEN-1:0]         pair_pc;
    logic [31:0]                 pair_inst0;
    logic [31:0]                 pair_inst1;
    logic                        pair_credit;
    logic                        commit_valid0;
    logic                        commit_valid1;
    dual_issue_pkg::issue_mode_e commit_mode;
    logic [`DI_XLEN-1:0]         commit_pc0;
    logic [`DI_XLEN-1:0]         commit_pc1;
    logic [`DI_RW-1:0]           commit_rd0;
    logic [`DI_RW-1:0]           commit_rd1;
    logic [`DI_XLEN-1:0]         commit_value0;
    logic [`DI_XLEN-1:0]         commit_value1;

    int                  credits;
    logic [`DI_XLEN-1:0] next_pc;
    string               test_name;

    `include "dual_issue_model.svh"

    dual_issue_top u_dut (
        .clk(clk), .rstn(rstn),
        .pair_valid(pair_valid), .pair_pc(pair_pc),
        .pair_inst0(pair_inst0), .pair_inst1(pair_inst1),
        .pair_credit(pair_credit),
        .commit_valid0(commit_valid0), .commit_valid1(commit_valid1),
        .commit_mode(commit_mode),
        .commit_pc0(commit_pc0), .commit_pc1(commit_pc1),
        .commit_rd0(commit_rd0), .commit_rd1(commit_rd1),
        .commit_value0(commit_value0), .commit_value1(commit_value1)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [`DI_XLEN-1:0] expv,
                               input logic [`DI_XLEN-1:0] actv);
        if (actv !== expv)
            stop_on_error($sformatf("Mismatch %s %s: expected %h, actual %h",
                                    test_name, what, expv, actv));
    endtask

    task automatic check_rd(input string what, input logic [`DI_RW-1:0] expv,
                            input logic [`DI_RW-1:0] actv);
        if (actv !== expv)
            stop_on_error($sformatf("Mismatch %s %s: expected r%0d, actual r%0d",
                                    test_name, what, expv, actv));
    endtask

    task automatic check_mode(input string what, input dual_issue_pkg::issue_mode_e expv,
                              input dual_issue_pkg::issue_mode_e actv);
        if (actv !== expv)
            stop_on_error($sformatf("Mismatch %s %s: expected %s, actual %s (%0d)",
                                    test_name, what, expv.name(), actv.name(), actv));
    endtask

    // one committed slot against the oldest outstanding model entry
    task automatic check_slot(input logic [`DI_XLEN-1:0] pc, input logic [`DI_RW-1:0] rd,
                              input logic [`DI_XLEN-1:0] value);
        if (exp_pc.size() == 0) begin
            stop_on_error($sformatf("%s: commit at pc %h with no instruction outstanding",
                                    test_name, pc));
        end else begin
            check_value("pc", exp_pc.pop_front(), pc);
            check_rd("rd", exp_rd.pop_front(), rd);
            check_value("value", exp_val.pop_front(), value);
            check_mode("mode", exp_mode.pop_front(), commit_mode);
        end
    endtask

    // advance one clock and sample the outputs away from the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (rstn) begin
            if (pair_credit) begin
                credits++;
                if (credits > `DI_CREDITS)
                    stop_on_error("pair_credit returned more credits than the driver spent");
            end
            if (commit_valid0)
                check_slot(commit_pc0, commit_rd0, commit_value0);
            if (commit_valid1)
                check_slot(commit_pc1, commit_rd1, commit_value1);
        end
    endtask

    task automatic send_pair(input logic [31:0] inst0, input logic [31:0] inst1);
        while (credits == 0)
            next_cycle();
        pair_valid = 1'b1;
        pair_pc    = next_pc;
        pair_inst0 = inst0;
        pair_inst1 = inst1;
        credits--;
        model_pair(next_pc, inst0, inst1);
        next_pc = next_pc + `DI_XLEN'd8;
        next_cycle();
        pair_valid = 1'b0;
    endtask

    task automatic apply_reset();
        rstn       = 1'b0;
        pair_valid = 1'b0;
        credits    = `DI_CREDITS;
        // anything still in flight is dropped
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
        exp_mode.delete();
        repeat (2) next_cycle();
        rstn = 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_pc.size() != 0)
            next_cycle();
        // idle cycles expose stray or repeated commits
        repeat (12) next_cycle();
    endtask

    function automatic logic [31:0] enc_rrr(input logic [5:0] op, input int rd, input int rj,
                                            input int rk);
        return {op, 5'(rd), 5'(rj), 5'(rk), 11'd0};
    endfunction

    function automatic logic [31:0] enc_addi(input int rd, input int rj,
                                             input logic [15:0] imm);
        return {6'(dual_issue_pkg::op_addi), 5'(rd), 5'(rj), imm};
    endfunction

    // registers limited to r0..r7 so hazards come up often
    function automatic logic [31:0] random_inst();
        int         sel;
        logic [5:0] op;
        sel = $urandom_range(0, 9);
        op  = (sel < 8) ? 6'(sel) : 6'($urandom_range(8, 63));
        return {op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                5'($urandom_range(0, 7)), 11'($urandom())};
    endfunction

    initial begin
        #(WATCH_NS);
        stop_on_error("watchdog expired, commits stopped arriving");
    end

    initial begin
        void'($urandom(66));
        clk        = 1'b0;
        rstn       = 1'b0;
        pair_valid = 1'b0;
        pair_pc    = '0;
        pair_inst0 = '0;
        pair_inst1 = '0;
        next_pc    = `DI_XLEN'h1000;
        test_name  = "reset";
        foreach (model_rf[i])
            model_rf[i] = '0;
        apply_reset();

        // known values in r1..r8 before anything reads them
        test_name = "preload";
        send_pair(enc_addi(1, 0, 16'h1234), enc_addi(2, 0, 16'hfff0));
        send_pair(enc_addi(3, 0, 16'h0f0f), enc_addi(4, 0, 16'h7001));
        send_pair(enc_addi(5, 0, 16'h00a5), enc_addi(6, 0, 16'h8000));
        send_pair(enc_addi(7, 0, 16'h0055), enc_addi(8, 0, 16'h0300));
        wait_drain();

        test_name = "independent_pair";
        send_pair(enc_rrr(OP_ADD, 9, 1, 2), enc_rrr(OP_SUB, 10, 3, 4));
        send_pair(enc_rrr(OP_AND, 11, 5, 6), enc_rrr(OP_OR, 12, 7, 8));
        send_pair(enc_rrr(OP_XOR, 13, 1, 8), enc_rrr(OP_ADD, 14, 2, 3));
        wait_drain();

        test_name = "dependent_pair";
        send_pair(enc_rrr(OP_ADD, 9, 1, 2), enc_rrr(OP_XOR, 10, 9, 3));
        send_pair(enc_rrr(OP_SUB, 11, 4, 5), enc_rrr(OP_OR, 12, 6, 11));
        send_pair(enc_addi(13, 13, 16'h0001), enc_rrr(OP_ADD, 14, 13, 13));
        wait_drain();

        test_name = "serializing";
        send_pair(enc_rrr(OP_PRIV, 9, 2, 0), enc_rrr(OP_ADD, 10, 3, 4));
        send_pair(enc_rrr(OP_ADD, 11, 1, 1), `DI_INST_NOP);
        send_pair(enc_rrr(OP_BAD, 12, 1, 2), enc_rrr(OP_AND, 13, 1, 2));
        send_pair(`DI_INST_NOP, `DI_INST_NOP);
        send_pair(enc_rrr(OP_OR, 14, 5, 6), enc_rrr(OP_PRIV, 9, 7, 0));
        wait_drain();

        test_name = "r0_and_same_rd";
        send_pair(enc_addi(0, 1, 16'h0007), enc_rrr(OP_ADD, 10, 0, 1));
        send_pair(enc_rrr(OP_ADD, 0, 3, 4), enc_rrr(OP_SUB, 11, 0, 2));
        send_pair(enc_rrr(OP_ADD, 12, 1, 2), enc_rrr(OP_SUB, 12, 3, 4));
        send_pair(enc_rrr(OP_OR, 13, 12, 0), enc_rrr(OP_XOR, 14, 0, 0));
        wait_drain();

        test_name = "random_burst";
        repeat (N_RANDOM)
            send_pair(random_inst(), random_inst());
        wait_drain();

        // in-flight pairs only touch r0, so the register file keeps its state
        test_name = "reset_mid_run";
        send_pair(enc_addi(0, 1, 16'h0005), enc_rrr(OP_ADD, 0, 2, 3));
        send_pair(enc_rrr(OP_SUB, 0, 4, 5), enc_rrr(OP_XOR, 0, 6, 7));
        apply_reset();
        repeat (20) next_cycle();

        test_name = "after_reset";
        repeat (8)
            send_pair(random_inst(), random_inst());
        wait_drain();

        $display("TEST PASSED");
        $finish;
    end

endmodule
